// ==== design/revive_pkg.sv ====
package revive_pkg;

    // ------------------------------------------------------------
    // Widths and sizes
    // ------------------------------------------------------------
    localparam int XLEN        = 32;
    localparam int NUM_REGS    = 16;
    localparam int REG_SEL_W   = 4;
    localparam int IMM_W       = 20;
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int MUL_STAGES  = 3;

    // Codes outside this list are treated as no-ops
    typedef enum logic [3:0] {
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_ADDI = 4'h6,
        OP_MUL  = 4'h7
    } opcode_e;

    // ------------------------------------------------------------
    // Instruction word, register and immediate forms
    // ------------------------------------------------------------
    typedef struct packed {
        opcode_e                op;
        logic [REG_SEL_W-1:0]   rd;
        logic [REG_SEL_W-1:0]   rs1;
        logic [REG_SEL_W-1:0]   rs2;
        logic [15:0]            unused;
    } instr_reg_t;

    typedef struct packed {
        opcode_e                op;
        logic [REG_SEL_W-1:0]   rd;
        logic [REG_SEL_W-1:0]   rs1;
        logic [IMM_W-1:0]       imm;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t rtype;
        instr_imm_t itype;
    } instr_u;

    // Issue record, scheduler to execution port
    typedef struct packed {
        logic                   valid;
        logic [REG_SEL_W-1:0]   rd;
        logic [XLEN-1:0]        a;
        logic [XLEN-1:0]        b;
        opcode_e                op;
    } issue_rec_t;

    // Writeback record, port request and arbiter output
    typedef struct packed {
        logic                   valid;
        logic [REG_SEL_W-1:0]   rd;
        logic [XLEN-1:0]        data;
    } wb_rec_t;

endpackage

// ==== design/instr_queue.sv ====
`timescale 1ns/1ps

module instr_queue (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_push,
    input  revive_pkg::instr_u  i_instr,
    input  logic                i_pop,
    output revive_pkg::instr_u  o_head,
    output logic                o_head_valid,
    output logic                o_credit
);
    import revive_pkg::*;

    instr_u                 mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W:0]   count;
    logic                   do_pop;

    function automatic logic [QUEUE_PTR_W-1:0] next_ptr(input logic [QUEUE_PTR_W-1:0] ptr);
        if (ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Sender credits guarantee there is room on every push
    assign do_pop       = i_pop & o_head_valid;
    assign o_head_valid = (count != '0);
    assign o_head       = mem[rd_ptr];

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_instr;
        end
    end

    // ------------------------------------------------------------
    // Pointers, occupancy and credit return
    // ------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({i_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back per freed entry
            o_credit <= do_pop;
        end
    end

endmodule

// ==== design/instr_sched.sv ====
`timescale 1ns/1ps

module instr_sched (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  revive_pkg::instr_u                i_head,
    input  logic                              i_head_valid,
    output logic                              o_pop,
    output logic [revive_pkg::REG_SEL_W-1:0]  o_rs1_sel,
    output logic [revive_pkg::REG_SEL_W-1:0]  o_rs2_sel,
    input  logic [revive_pkg::XLEN-1:0]       i_rs1_data,
    input  logic [revive_pkg::XLEN-1:0]       i_rs2_data,
    input  logic                              i_alu_ready,
    input  logic                              i_mul_ready,
    output revive_pkg::issue_rec_t            o_alu_issue,
    output revive_pkg::issue_rec_t            o_mul_issue,
    input  revive_pkg::wb_rec_t               i_wb
);
    import revive_pkg::*;

    opcode_e                op;
    logic [REG_SEL_W-1:0]   rd;
    logic [REG_SEL_W-1:0]   rs1;
    logic [REG_SEL_W-1:0]   rs2;
    logic [IMM_W-1:0]       imm;
    logic                   is_alu;
    logic                   is_mul;
    logic                   is_imm;
    logic                   hazard;
    logic                   discard;
    logic                   issue_alu;
    logic                   issue_mul;
    logic [XLEN-1:0]        operand_b;
    logic [NUM_REGS-1:0]    pending;
    logic [NUM_REGS-1:0]    wb_clear;
    logic [NUM_REGS-1:0]    busy;
    logic [NUM_REGS-1:0]    issue_set;
    issue_rec_t             issue_rec;

    // ------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------
    assign op  = i_head.rtype.op;
    assign rd  = i_head.rtype.rd;
    assign rs1 = i_head.rtype.rs1;
    assign rs2 = i_head.rtype.rs2;
    assign imm = i_head.itype.imm;

    always_comb begin
        is_alu = 1'b0;
        is_mul = 1'b0;
        is_imm = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: is_alu = 1'b1;
            OP_ADDI: begin
                is_alu = 1'b1;
                is_imm = 1'b1;
            end
            OP_MUL:  is_mul = 1'b1;
            default: ;
        endcase
    end

    assign o_rs1_sel = rs1;
    assign o_rs2_sel = rs2;
    assign operand_b = is_imm ? {{(XLEN - IMM_W){imm[IMM_W-1]}}, imm} : i_rs2_data;

    // ------------------------------------------------------------
    // Hazard check and issue
    // ------------------------------------------------------------
    // A writeback this cycle frees its register, the file bypasses the data
    assign wb_clear = i_wb.valid ? (NUM_REGS'(1) << i_wb.rd) : '0;
    assign busy     = pending & ~wb_clear;
    assign hazard   = busy[rs1] | (~is_imm & busy[rs2]) | busy[rd];

    assign discard   = i_head_valid & ((rd == '0) | ~(is_alu | is_mul));
    assign issue_alu = i_head_valid & ~discard & is_alu & ~hazard & i_alu_ready;
    assign issue_mul = i_head_valid & ~discard & is_mul & ~hazard & i_mul_ready;
    assign o_pop     = issue_alu | issue_mul | discard;

    assign issue_rec = '{valid: 1'b0, rd: rd, a: i_rs1_data, b: operand_b, op: op};

    always_comb begin
        o_alu_issue       = issue_rec;
        o_alu_issue.valid = issue_alu;
        o_mul_issue       = issue_rec;
        o_mul_issue.valid = issue_mul;
    end

    // Scoreboard
    assign issue_set = (issue_alu | issue_mul) ? (NUM_REGS'(1) << rd) : '0;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pending <= '0;
        end else begin
            pending <= busy | issue_set;
        end
    end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                              i_clk,
    input  logic                              i_rst_n,
    input  logic [revive_pkg::REG_SEL_W-1:0]  i_rs1_sel,
    input  logic [revive_pkg::REG_SEL_W-1:0]  i_rs2_sel,
    output logic [revive_pkg::XLEN-1:0]       o_rs1_data,
    output logic [revive_pkg::XLEN-1:0]       o_rs2_data,
    input  revive_pkg::wb_rec_t               i_wb
);
    import revive_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    // Write-first read, register 0 hardwired to zero
    function automatic logic [XLEN-1:0] read_port(input logic [REG_SEL_W-1:0] sel);
        if (sel == '0) begin
            return '0;
        end
        if (i_wb.valid && (i_wb.rd == sel)) begin
            return i_wb.data;
        end
        return regs[sel];
    endfunction

    always_comb begin
        o_rs1_data = read_port(i_rs1_sel);
        o_rs2_data = read_port(i_rs2_sel);
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.valid && (i_wb.rd != '0)) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

endmodule

// ==== design/exec_alu_port.sv ====
`timescale 1ns/1ps

module exec_alu_port (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  revive_pkg::issue_rec_t  i_issue,
    input  logic                    i_grant,
    output logic                    o_ready,
    output revive_pkg::wb_rec_t     o_req
);
    import revive_pkg::*;

    logic                   hold_valid;
    logic [REG_SEL_W-1:0]   hold_rd;
    logic [XLEN-1:0]        hold_data;
    logic [XLEN-1:0]        result;

    always_comb begin
        case (i_issue.op)
            OP_ADD, OP_ADDI: result = i_issue.a + i_issue.b;
            OP_SUB:          result = i_issue.a - i_issue.b;
            OP_AND:          result = i_issue.a & i_issue.b;
            OP_OR:           result = i_issue.a | i_issue.b;
            OP_XOR:          result = i_issue.a ^ i_issue.b;
            default:         result = '0;
        endcase
    end

    // Free when empty, or when the held result leaves this cycle
    assign o_ready = ~hold_valid | i_grant;
    assign o_req   = '{valid: hold_valid, rd: hold_rd, data: hold_data};

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            hold_valid <= 1'b0;
        end else if (i_issue.valid) begin
            hold_valid <= 1'b1;
        end else if (i_grant) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_issue.valid) begin
            hold_rd   <= i_issue.rd;
            hold_data <= result;
        end
    end

endmodule

// ==== design/exec_mul_port.sv ====
`timescale 1ns/1ps

module exec_mul_port (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  revive_pkg::issue_rec_t  i_issue,
    input  logic                    i_grant,
    output logic                    o_ready,
    output revive_pkg::wb_rec_t     o_req
);
    import revive_pkg::*;

    logic [MUL_STAGES-1:0]  stg_valid;
    logic [MUL_STAGES-1:0]  stg_free;
    logic [REG_SEL_W-1:0]   stg_rd   [MUL_STAGES];
    logic [XLEN-1:0]        stg_data [MUL_STAGES];
    logic [XLEN-1:0]        product;

    // Low half only, carried down the stages for retiming
    assign product = i_issue.a * i_issue.b;

    // ------------------------------------------------------------
    // Stage flow control
    // ------------------------------------------------------------
    // A stage can load when it is empty or its contents move on
    always_comb begin
        stg_free[MUL_STAGES-1] = ~stg_valid[MUL_STAGES-1] | i_grant;
        for (int k = MUL_STAGES - 2; k >= 0; k--) begin
            stg_free[k] = ~stg_valid[k] | stg_free[k+1];
        end
    end

    assign o_ready = stg_free[0];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            stg_valid <= '0;
        end else begin
            if (stg_free[0]) begin
                stg_valid[0] <= i_issue.valid;
            end
            for (int k = 1; k < MUL_STAGES; k++) begin
                if (stg_free[k]) begin
                    stg_valid[k] <= stg_valid[k-1];
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (stg_free[0]) begin
            stg_rd[0]   <= i_issue.rd;
            stg_data[0] <= product;
        end
        for (int k = 1; k < MUL_STAGES; k++) begin
            if (stg_free[k]) begin
                stg_rd[k]   <= stg_rd[k-1];
                stg_data[k] <= stg_data[k-1];
            end
        end
    end

    // Last stage doubles as the hold stage
    assign o_req = '{valid: stg_valid[MUL_STAGES-1],
                     rd:    stg_rd[MUL_STAGES-1],
                     data:  stg_data[MUL_STAGES-1]};

endmodule

// ==== design/writeback_arbiter.sv ====
`timescale 1ns/1ps

module writeback_arbiter (
    input  revive_pkg::wb_rec_t i_alu_req,
    input  revive_pkg::wb_rec_t i_mul_req,
    output logic                o_alu_grant,
    output logic                o_mul_grant,
    output revive_pkg::wb_rec_t o_wb
);

    // ------------------------------------------------------------
    // Fixed priority
    // ------------------------------------------------------------
    // Multiplier first, its hold stage backs up the whole pipeline
    assign o_mul_grant = i_mul_req.valid;
    assign o_alu_grant = i_alu_req.valid & ~i_mul_req.valid;

    // Losing request keeps its hold register until a later grant
    always_comb begin
        if (o_mul_grant) begin
            o_wb = i_mul_req;
        end else if (o_alu_grant) begin
            o_wb = i_alu_req;
        end else begin
            o_wb = '0;
        end
    end

endmodule

// ==== design/revive_core.sv ====
`timescale 1ns/1ps

module revive_core (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_instr_valid,
    input  revive_pkg::instr_u  i_instr,
    output logic                o_credit,
    output revive_pkg::wb_rec_t o_wb
);
    import revive_pkg::*;

    instr_u                 head;
    logic                   head_valid;
    logic                   pop;
    logic [REG_SEL_W-1:0]   rs1_sel;
    logic [REG_SEL_W-1:0]   rs2_sel;
    logic [XLEN-1:0]        rs1_data;
    logic [XLEN-1:0]        rs2_data;
    logic                   alu_ready;
    logic                   mul_ready;
    issue_rec_t             alu_issue;
    issue_rec_t             mul_issue;
    wb_rec_t                alu_req;
    wb_rec_t                mul_req;
    logic                   alu_grant;
    logic                   mul_grant;
    wb_rec_t                wb;

    assign o_wb = wb;

    // ------------------------------------------------------------
    // Front: queue, scheduler, register file
    // ------------------------------------------------------------
    instr_queue u_queue (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_push         (i_instr_valid),
        .i_instr        (i_instr),
        .i_pop          (pop),
        .o_head         (head),
        .o_head_valid   (head_valid),
        .o_credit       (o_credit)
    );

    instr_sched u_sched (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_head         (head),
        .i_head_valid   (head_valid),
        .o_pop          (pop),
        .o_rs1_sel      (rs1_sel),
        .o_rs2_sel      (rs2_sel),
        .i_rs1_data     (rs1_data),
        .i_rs2_data     (rs2_data),
        .i_alu_ready    (alu_ready),
        .i_mul_ready    (mul_ready),
        .o_alu_issue    (alu_issue),
        .o_mul_issue    (mul_issue),
        .i_wb           (wb)
    );

    reg_file u_rf (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_rs1_sel      (rs1_sel),
        .i_rs2_sel      (rs2_sel),
        .o_rs1_data     (rs1_data),
        .o_rs2_data     (rs2_data),
        .i_wb           (wb)
    );

    // ------------------------------------------------------------
    // Execution ports and writeback
    // ------------------------------------------------------------
    exec_alu_port u_alu (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_issue        (alu_issue),
        .i_grant        (alu_grant),
        .o_ready        (alu_ready),
        .o_req          (alu_req)
    );

    exec_mul_port u_mul (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_issue        (mul_issue),
        .i_grant        (mul_grant),
        .o_ready        (mul_ready),
        .o_req          (mul_req)
    );

    writeback_arbiter u_arb (
        .i_alu_req      (alu_req),
        .i_mul_req      (mul_req),
        .o_alu_grant    (alu_grant),
        .o_mul_grant    (mul_grant),
        .o_wb           (wb)
    );

endmodule

// ==== sim/tb_revive_core.sv ====
`timescale 1ns/1ps

module tb_revive_core;
    import revive_pkg::*;

    localparam int PAT_COUNT    = 20;
    localparam int RESET_CYCLES = 16;
    localparam int RUN_LIMIT    = 2000;
    localparam int QUIET_CYCLES = 20;

    logic       i_clk;
    logic       i_rst_n;
    logic       i_instr_valid;
    instr_u     i_instr;
    logic       o_credit;
    wb_rec_t    o_wb;

    // Flag nibble, instruction word, expected writeback data
    logic [67:0] pats [0:PAT_COUNT-1];
    logic        chain_entry [PAT_COUNT];
    int          exp_q [NUM_REGS][$];

    int seed;
    int credits;
    int credits_back;
    int wb_seen;
    int wb_expected;
    int checks;
    int errors;
    int alu_checks;
    int alu_errs;
    int mul_checks;
    int mul_errs;
    int chain_checks;
    int chain_errs;

    revive_core DUT (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .o_credit       (o_credit),
        .o_wb           (o_wb)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #4 i_clk = ~i_clk;
        end
    end

    // ------------------------------------------------------------
    // Pattern loading and writeback checking
    // ------------------------------------------------------------
    task automatic load_patterns(output bit ok);
        logic [3:0]           op;
        logic [REG_SEL_W-1:0] rd;
        logic [REG_SEL_W-1:0] rs1;
        logic [REG_SEL_W-1:0] rs2;
        logic [REG_SEL_W-1:0] last_rd;
        bit                   have_last;
        $readmemh("sim/revive_patterns.hex", pats);
        ok = (^pats[PAT_COUNT-1] !== 1'bx);
        if (!ok) begin
            $display("Pattern file is missing or holds fewer than %0d entries", PAT_COUNT);
            errors++;
            return;
        end
        have_last = 1'b0;
        last_rd   = '0;
        for (int i = 0; i < PAT_COUNT; i++) begin
            op  = pats[i][63:60];
            rd  = pats[i][59:56];
            rs1 = pats[i][55:52];
            rs2 = pats[i][51:48];
            // Reads the register of the last word that writes back
            chain_entry[i] = have_last && pats[i][64] &&
                             ((rs1 == last_rd) || ((op != OP_ADDI) && (rs2 == last_rd)));
            if (pats[i][64]) begin
                exp_q[rd].push_back(i);
                wb_expected++;
                have_last = 1'b1;
                last_rd   = rd;
            end
        end
    endtask

    task automatic check_writeback();
        int              idx;
        logic [XLEN-1:0] want;
        bit              bad;
        if (exp_q[o_wb.rd].size() == 0) begin
            $display("Unexpected writeback to register %0d", o_wb.rd);
            errors++;
            return;
        end
        idx  = exp_q[o_wb.rd].pop_front();
        want = pats[idx][31:0];
        bad  = (o_wb.data !== want);
        checks++;
        if (bad) begin
            $display("ERROR: o_wb.data entry %0d r%0d expected 0x%h actual 0x%h",
                     idx, o_wb.rd, want, o_wb.data);
            errors++;
        end
        if (pats[idx][63:60] == OP_MUL) begin
            mul_checks++;
            mul_errs += bad;
        end else begin
            alu_checks++;
            alu_errs += bad;
        end
        if (chain_entry[idx]) begin
            chain_checks++;
            chain_errs += bad;
        end
    endtask

    task automatic sample_outputs();
        if (o_credit === 1'b1) begin
            credits++;
            credits_back++;
            if (credits > QUEUE_DEPTH) begin
                $display("Credit returned while no word was outstanding");
                errors++;
            end
        end
        if (o_wb.valid === 1'b1) begin
            wb_seen++;
            check_writeback();
        end
    endtask

    task automatic compare_count(input string name, input int want, input int got,
                                 inout int n, inout int bad);
        n++;
        checks++;
        if (want != got) begin
            $display("ERROR: %s expected 0x%h actual 0x%h", name, want, got);
            bad++;
            errors++;
        end
    endtask

    function automatic void report_test(input string name, input int n, input int bad);
        if (bad == 0) begin
            $display("%s: %0d checks, pass", name, n);
        end else begin
            $display("%s: %0d checks, %0d wrong, FAIL", name, n, bad);
        end
    endfunction

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        int gap;
        int cycles;
        int idx;
        int n;
        int bad;
        int left;
        bit file_ok;
        i_rst_n       = 1'b0;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        seed          = 90;
        credits       = QUEUE_DEPTH;
        load_patterns(file_ok);

        // Outputs stay quiet in reset and one cycle beyond
        n   = 0;
        bad = 0;
        for (cycles = 0; cycles <= RESET_CYCLES; cycles++) begin
            @(negedge i_clk);
            n      += 2;
            checks += 2;
            if (o_credit !== 1'b0) begin
                $display("ERROR: o_credit expected 0x0 actual 0x%h", o_credit);
                bad++;
                errors++;
            end
            if (o_wb.valid !== 1'b0) begin
                $display("ERROR: o_wb.valid expected 0x0 actual 0x%h", o_wb.valid);
                bad++;
                errors++;
            end
            if (cycles == RESET_CYCLES - 1) begin
                i_rst_n = 1'b1;
            end
        end
        report_test("test 1 reset quiet", n, bad);

        idx    = 0;
        cycles = 0;
        while (file_ok && (idx < PAT_COUNT || wb_seen < wb_expected
                           || credits_back < PAT_COUNT)) begin
            @(negedge i_clk);
            sample_outputs();
            i_instr_valid = 1'b0;
            gap = $random(seed);
            if (idx < PAT_COUNT && credits > 0 && gap[1:0] != 2'b00) begin
                i_instr_valid = 1'b1;
                i_instr       = pats[idx][63:32];
                credits--;
                idx++;
            end
            cycles++;
            if (cycles >= RUN_LIMIT) begin
                $display("Timeout after %0d cycles with %0d words pushed and %0d writebacks",
                         cycles, idx, wb_seen);
                errors++;
                file_ok = 1'b0;
            end
        end
        i_instr_valid = 1'b0;

        // Nothing more may arrive once the stream has drained
        for (cycles = 0; cycles < QUIET_CYCLES; cycles++) begin
            @(negedge i_clk);
            sample_outputs();
        end
        report_test("test 2 alu results", alu_checks, alu_errs);
        report_test("test 3 mul results", mul_checks, mul_errs);
        report_test("test 4 dependent chain", chain_checks, chain_errs);

        n    = 0;
        bad  = 0;
        left = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            left += exp_q[r].size();
        end
        compare_count("credits returned", idx, credits_back, n, bad);
        compare_count("writebacks seen", wb_expected, wb_seen, n, bad);
        compare_count("writebacks missing", 0, left, n, bad);
        report_test("test 5 credit and writeback counts", n, bad);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/revive_patterns.hex ====
// Columns: flag (1 = writeback expected), instruction word, expected data
// Word layout: op[31:28] rd[27:24] rs1[23:20] rs2[19:16] or imm[19:0]
1_61000005_00000005
1_620FFFFD_FFFFFFFD
1_13120000_00000002
1_24120000_00000008
1_6500F0F0_0000F0F0
1_36520000_0000F0F0
1_47510000_0000F0F5
1_58720000_FFFF0F08
1_79140000_00000028
1_7A220000_00000009
1_6BA12345_0001234E
1_7C980000_FFDA5940
1_1DC30000_FFDA5942
0_60100007_00000000
0_F1120000_00000000
1_21D10000_FFDA593D
1_73340000_00000010
1_5E130000_FFDA592D
1_6FE80000_FFD2592D
1_72F00000_00000000

// ==== revive_core.f ====
design/revive_pkg.sv
design/instr_queue.sv
design/instr_sched.sv
design/reg_file.sv
design/exec_alu_port.sv
design/exec_mul_port.sv
design/writeback_arbiter.sv
design/revive_core.sv
sim/tb_revive_core.sv

// ==== Bender.yml ====
package:
  name: revive_core

sources:
  - design/revive_pkg.sv
  - design/instr_queue.sv
  - design/instr_sched.sv
  - design/reg_file.sv
  - design/exec_alu_port.sv
  - design/exec_mul_port.sv
  - design/writeback_arbiter.sv
  - design/revive_core.sv
  - target: simulation
    files:
      - sim/tb_revive_core.sv
